// ==== build.f ====
source/core_cfg_pkg.sv
source/stage_bus_pkg.sv
source/exec_stage.sv
source/data_sram.sv
source/mem_stage.sv
source/wb_stage.sv
source/lsu_pipe_top.sv
tests/tb_lsu_pipe.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the pipeline back-end testbench with Verilator

set -u
cd "$(dirname "$0")"

obj_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -f build.f \
    --top-module tb_lsu_pipe -Mdir "${obj_dir}" -o sim_lsu_pipe
build_status=$?
if [ ${build_status} -ne 0 ]; then
    echo "Verilator build failed with status ${build_status}"
    exit 1
fi

"./${obj_dir}/sim_lsu_pipe" > "${log_file}" 2>&1
run_status=$?
cat "${log_file}"
if [ ${run_status} -ne 0 ]; then
    echo "Simulation exited with status ${run_status}"
    exit 1
fi

if grep -qF "** FAIL **" "${log_file}"; then
    echo "Simulation reported failure"
    exit 1
fi

echo "Simulation finished without failure"
exit 0

// ==== source/core_cfg_pkg.sv ====
/*
 * Core configuration
 * Data-path widths and memory-operation encodings shared by the pipeline
 */

`default_nettype none

package core_cfg_pkg;

    // ----------------------------------------
    // Data-path widths
    // ----------------------------------------
    localparam int XLEN      = 64;
    localparam int RF_ADDR_W = 5;
    localparam int PC_W      = 32;

    // ----------------------------------------
    // Encodings
    // ----------------------------------------
    // Access size, bytes = 1 << size
    typedef enum logic [1:0] {
        SIZE_B = 2'd0,
        SIZE_H = 2'd1,
        SIZE_W = 2'd2,
        SIZE_D = 2'd3
    } mem_size_t;

    // Pre-decoded operation class
    typedef enum logic [1:0] {
        OP_ADDI  = 2'd0,
        OP_LOAD  = 2'd1,
        OP_STORE = 2'd2
    } op_kind_t;

endpackage

`default_nettype wire

// ==== source/data_sram.sv ====
/*
 * Data SRAM
 * Byte-lane writes and a registered read that holds between reads
 */

`timescale 1ns/1ps
`default_nettype none

module data_sram
    import core_cfg_pkg::*;
    import stage_bus_pkg::*;
#(
    parameter int DMEM_WORDS = 256
) (
    input  logic            clk,
    input  sram_req_t       sram_req,
    output logic [XLEN-1:0] rdata
);

    localparam int IDX_W = $clog2(DMEM_WORDS);

    logic [XLEN-1:0]  mem [DMEM_WORDS];
    logic [IDX_W-1:0] addr;

    assign addr = sram_req.index[IDX_W-1:0];

    // Unwritten words read as zero
    initial begin
        for (int i = 0; i < DMEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    always @(posedge clk) begin
        if (sram_req.en_wr) begin
            for (int b = 0; b < XLEN/8; b++) begin
                if (sram_req.byte_mask[b]) begin
                    mem[addr][b*8 +: 8] <= sram_req.wdata[b*8 +: 8];
                end
            end
        end
    end

    // Output only moves on a read
    always_ff @(posedge clk) begin
        if (sram_req.en_rd) begin
            rdata <= mem[addr];
        end
    end

endmodule

`default_nettype wire

// ==== source/exec_stage.sv ====
/*
 * Execute stage
 * Resolves operands through forwarding, computes result or address,
 * and issues the data SRAM access for loads and stores
 */

`timescale 1ns/1ps
`default_nettype none

module exec_stage
    import core_cfg_pkg::*;
    import stage_bus_pkg::*;
#(
    parameter int DMEM_WORDS = 256
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 in_valid,
    input  issue_bus_t           in_bus,
    output logic                 in_allowin,
    input  logic                 ms_allowin,
    output logic                 es_to_ms_valid,
    output es_to_ms_bus_t        es_to_ms_bus,
    output logic [RF_ADDR_W-1:0] rf_rs1_addr,
    output logic [RF_ADDR_W-1:0] rf_rs2_addr,
    input  logic [XLEN-1:0]      rf_rs1_data,
    input  logic [XLEN-1:0]      rf_rs2_data,
    input  forward_bus_t         ms_forward,
    input  forward_bus_t         ws_forward,
    output sram_req_t            sram_req
);

    localparam int IDX_W = $clog2(DMEM_WORDS);

    logic            es_valid;
    logic            es_allowin;
    logic            es_fire;
    issue_bus_t      es_bus_r;
    logic [XLEN-1:0] src1;
    logic [XLEN-1:0] src2;
    logic [XLEN-1:0] es_addr;
    logic [XLEN-1:0] st_data;
    logic [2:0]      byte_off;
    logic [7:0]      byte_mask;
    logic [XLEN-4:0] word_index;

    // Memory stage result wins over writeback, then the register file
    function automatic logic [XLEN-1:0] resolve_src(
        input logic [RF_ADDR_W-1:0] rs,
        input forward_bus_t         ms_fwd,
        input forward_bus_t         ws_fwd,
        input logic [XLEN-1:0]      rf_data
    );
        logic [XLEN-1:0] value;
        if (rs == '0) begin
            value = '0;
        end else if (ms_fwd.valid && ms_fwd.rd == rs) begin
            value = ms_fwd.value;
        end else if (ws_fwd.valid && ws_fwd.rd == rs) begin
            value = ws_fwd.value;
        end else begin
            value = rf_data;
        end
        return value;
    endfunction

    // ----------------------------------------
    // Stage register and handshake
    // ----------------------------------------
    assign es_allowin     = !es_valid || ms_allowin;
    assign in_allowin     = es_allowin;
    assign es_to_ms_valid = es_valid;
    assign es_fire        = es_valid && ms_allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            es_valid <= 1'b0;
        end else if (es_allowin) begin
            es_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && es_allowin) begin
            es_bus_r <= in_bus;
        end
    end

    // ----------------------------------------
    // Operands and address
    // ----------------------------------------
    assign rf_rs1_addr = es_bus_r.rs1;
    assign rf_rs2_addr = es_bus_r.rs2;

    assign src1     = resolve_src(es_bus_r.rs1, ms_forward, ws_forward, rf_rs1_data);
    assign src2     = resolve_src(es_bus_r.rs2, ms_forward, ws_forward, rf_rs2_data);
    assign es_addr  = src1 + es_bus_r.imm;
    assign byte_off = es_addr[2:0];

    // Store data moved into the addressed lanes
    assign st_data = src2 << {byte_off, 3'b000};

    always_comb begin
        case (es_bus_r.size)
            SIZE_B:  byte_mask = 8'h01 << byte_off;
            SIZE_H:  byte_mask = 8'h03 << byte_off;
            SIZE_W:  byte_mask = 8'h0f << byte_off;
            default: byte_mask = 8'hff;
        endcase
    end

    // Word number wraps at the memory size
    always_comb begin
        word_index = '0;
        word_index[IDX_W-1:0] = es_addr[3 +: IDX_W];
    end

    // ----------------------------------------
    // Outputs
    // ----------------------------------------
    always_comb begin
        sram_req.en_rd     = es_fire && es_bus_r.kind == OP_LOAD;
        sram_req.en_wr     = es_fire && es_bus_r.kind == OP_STORE;
        sram_req.index     = word_index;
        sram_req.byte_mask = byte_mask;
        sram_req.wdata     = st_data;
    end

    always_comb begin
        es_to_ms_bus.mem_re     = es_bus_r.kind == OP_LOAD;
        es_to_ms_bus.size       = es_bus_r.size;
        es_to_ms_bus.sign_ext   = es_bus_r.sign_ext;
        es_to_ms_bus.byte_off   = byte_off;
        es_to_ms_bus.rf_we      = es_bus_r.kind != OP_STORE;
        es_to_ms_bus.rd         = es_bus_r.rd;
        es_to_ms_bus.alu_result = es_addr;
        es_to_ms_bus.pc         = es_bus_r.pc;
    end

endmodule

`default_nettype wire

// ==== source/lsu_pipe_top.sv ====
/*
 * Pipeline back end top level
 * Execute, memory and writeback stages around a data SRAM
 */

`timescale 1ns/1ps
`default_nettype none

module lsu_pipe_top
    import core_cfg_pkg::*;
    import stage_bus_pkg::*;
#(
    parameter int DMEM_WORDS = 256
) (
    input  logic          clk,
    input  logic          reset,
    input  logic          in_valid,
    input  issue_bus_t    in_bus,
    output logic          in_allowin,
    output logic          retire_valid,
    output ms_to_ws_bus_t retire_bus,
    input  logic          retire_ready
);

    // ----------------------------------------
    // Inter-stage wiring
    // ----------------------------------------
    logic                 es_to_ms_valid;
    es_to_ms_bus_t        es_to_ms_bus;
    logic                 ms_allowin;
    logic                 ms_to_ws_valid;
    ms_to_ws_bus_t        ms_to_ws_bus;
    logic                 ws_allowin;
    logic [RF_ADDR_W-1:0] rf_rs1_addr;
    logic [RF_ADDR_W-1:0] rf_rs2_addr;
    logic [XLEN-1:0]      rf_rs1_data;
    logic [XLEN-1:0]      rf_rs2_data;
    forward_bus_t         ms_forward;
    forward_bus_t         ws_forward;
    sram_req_t            sram_req;
    logic [XLEN-1:0]      sram_rdata;

    exec_stage #(
        .DMEM_WORDS(DMEM_WORDS)
    ) exec_stage_i (
        .clk           (clk),
        .reset         (reset),
        .in_valid      (in_valid),
        .in_bus        (in_bus),
        .in_allowin    (in_allowin),
        .ms_allowin    (ms_allowin),
        .es_to_ms_valid(es_to_ms_valid),
        .es_to_ms_bus  (es_to_ms_bus),
        .rf_rs1_addr   (rf_rs1_addr),
        .rf_rs2_addr   (rf_rs2_addr),
        .rf_rs1_data   (rf_rs1_data),
        .rf_rs2_data   (rf_rs2_data),
        .ms_forward    (ms_forward),
        .ws_forward    (ws_forward),
        .sram_req      (sram_req)
    );

    data_sram #(
        .DMEM_WORDS(DMEM_WORDS)
    ) data_sram_i (
        .clk     (clk),
        .sram_req(sram_req),
        .rdata   (sram_rdata)
    );

    mem_stage mem_stage_i (
        .clk           (clk),
        .reset         (reset),
        .es_to_ms_valid(es_to_ms_valid),
        .es_to_ms_bus  (es_to_ms_bus),
        .ms_allowin    (ms_allowin),
        .ws_allowin    (ws_allowin),
        .ms_to_ws_valid(ms_to_ws_valid),
        .ms_to_ws_bus  (ms_to_ws_bus),
        .sram_rdata    (sram_rdata),
        .ms_forward    (ms_forward)
    );

    // Register file lives in writeback
    wb_stage wb_stage_i (
        .clk           (clk),
        .reset         (reset),
        .ms_to_ws_valid(ms_to_ws_valid),
        .ms_to_ws_bus  (ms_to_ws_bus),
        .ws_allowin    (ws_allowin),
        .retire_valid  (retire_valid),
        .retire_bus    (retire_bus),
        .retire_ready  (retire_ready),
        .rs1_addr      (rf_rs1_addr),
        .rs2_addr      (rf_rs2_addr),
        .rs1_data      (rf_rs1_data),
        .rs2_data      (rf_rs2_data),
        .ws_forward    (ws_forward)
    );

endmodule

`default_nettype wire

// ==== source/mem_stage.sv ====
/*
 * Memory stage
 * Aligns and extends load data, picks the final result and forwards it
 */

`timescale 1ns/1ps
`default_nettype none

module mem_stage
    import core_cfg_pkg::*;
    import stage_bus_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  logic            es_to_ms_valid,
    input  es_to_ms_bus_t   es_to_ms_bus,
    output logic            ms_allowin,
    input  logic            ws_allowin,
    output logic            ms_to_ws_valid,
    output ms_to_ws_bus_t   ms_to_ws_bus,
    input  logic [XLEN-1:0] sram_rdata,
    output forward_bus_t    ms_forward
);

    logic            ms_valid;
    es_to_ms_bus_t   ms_bus_r;
    logic [XLEN-1:0] lane_data;
    logic [XLEN-1:0] load_value;
    logic [XLEN-1:0] final_result;

    // ----------------------------------------
    // Stage register and handshake
    // ----------------------------------------
    assign ms_allowin     = !ms_valid || ws_allowin;
    assign ms_to_ws_valid = ms_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            ms_valid <= 1'b0;
        end else if (ms_allowin) begin
            ms_valid <= es_to_ms_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (es_to_ms_valid && ms_allowin) begin
            ms_bus_r <= es_to_ms_bus;
        end
    end

    // ----------------------------------------
    // Load alignment and extension
    // ----------------------------------------
    assign lane_data = sram_rdata >> {ms_bus_r.byte_off, 3'b000};

    always_comb begin
        case (ms_bus_r.size)
            SIZE_B: load_value = {{(XLEN-8){ms_bus_r.sign_ext & lane_data[7]}},
                                  lane_data[7:0]};
            SIZE_H: load_value = {{(XLEN-16){ms_bus_r.sign_ext & lane_data[15]}},
                                  lane_data[15:0]};
            SIZE_W: load_value = {{(XLEN-32){ms_bus_r.sign_ext & lane_data[31]}},
                                  lane_data[31:0]};
            default: load_value = lane_data;
        endcase
    end

    assign final_result = ms_bus_r.mem_re ? load_value : ms_bus_r.alu_result;

    always_comb begin
        ms_to_ws_bus.rf_we        = ms_bus_r.rf_we;
        ms_to_ws_bus.rd           = ms_bus_r.rd;
        ms_to_ws_bus.final_result = final_result;
        ms_to_ws_bus.pc           = ms_bus_r.pc;
    end

    // Bypass, never for x0
    always_comb begin
        ms_forward.valid = ms_valid && ms_bus_r.rf_we && ms_bus_r.rd != '0;
        ms_forward.rd    = ms_bus_r.rd;
        ms_forward.value = final_result;
    end

endmodule

`default_nettype wire

// ==== source/stage_bus_pkg.sv ====
/*
 * Stage buses
 * Packed structs passed between pipeline stages, to the SRAM and out of the core
 */

`default_nettype none

package stage_bus_pkg;

    import core_cfg_pkg::*;

    // Decoded instruction from the issue side
    typedef struct packed {
        op_kind_t              kind;
        mem_size_t             size;
        logic                  sign_ext;
        logic [RF_ADDR_W-1:0]  rs1;
        logic [RF_ADDR_W-1:0]  rs2;
        logic [RF_ADDR_W-1:0]  rd;
        logic [XLEN-1:0]       imm;
        logic [PC_W-1:0]       pc;
    } issue_bus_t;

    // Execute to memory
    typedef struct packed {
        logic                  mem_re;
        mem_size_t             size;
        logic                  sign_ext;
        logic [2:0]            byte_off;
        logic                  rf_we;
        logic [RF_ADDR_W-1:0]  rd;
        logic [XLEN-1:0]       alu_result;
        logic [PC_W-1:0]       pc;
    } es_to_ms_bus_t;

    // Memory to writeback, also the retire record
    typedef struct packed {
        logic                  rf_we;
        logic [RF_ADDR_W-1:0]  rd;
        logic [XLEN-1:0]       final_result;
        logic [PC_W-1:0]       pc;
    } ms_to_ws_bus_t;

    // Result bypass back to execute
    typedef struct packed {
        logic                  valid;
        logic [RF_ADDR_W-1:0]  rd;
        logic [XLEN-1:0]       value;
    } forward_bus_t;

    // Data SRAM request, index is a 64-bit word number
    typedef struct packed {
        logic                  en_rd;
        logic                  en_wr;
        logic [XLEN-4:0]       index;
        logic [XLEN/8-1:0]     byte_mask;
        logic [XLEN-1:0]       wdata;
    } sram_req_t;

endpackage

`default_nettype wire

// ==== source/wb_stage.sv ====
/*
 * Writeback stage
 * Holds the retiring instruction and the register file, written on retire
 */

`timescale 1ns/1ps
`default_nettype none

module wb_stage
    import core_cfg_pkg::*;
    import stage_bus_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 ms_to_ws_valid,
    input  ms_to_ws_bus_t        ms_to_ws_bus,
    output logic                 ws_allowin,
    output logic                 retire_valid,
    output ms_to_ws_bus_t        retire_bus,
    input  logic                 retire_ready,
    input  logic [RF_ADDR_W-1:0] rs1_addr,
    input  logic [RF_ADDR_W-1:0] rs2_addr,
    output logic [XLEN-1:0]      rs1_data,
    output logic [XLEN-1:0]      rs2_data,
    output forward_bus_t         ws_forward
);

    localparam int RF_DEPTH = 1 << RF_ADDR_W;

    logic            ws_valid;
    ms_to_ws_bus_t   ws_bus_r;
    logic            retire_fire;
    logic            rf_write;
    logic [XLEN-1:0] rf [RF_DEPTH];

    // ----------------------------------------
    // Stage register and retire handshake
    // ----------------------------------------
    assign ws_allowin   = !ws_valid || retire_ready;
    assign retire_valid = ws_valid;
    assign retire_bus   = ws_bus_r;
    assign retire_fire  = ws_valid && retire_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            ws_valid <= 1'b0;
        end else if (ws_allowin) begin
            ws_valid <= ms_to_ws_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ms_to_ws_valid && ws_allowin) begin
            ws_bus_r <= ms_to_ws_bus;
        end
    end

    // ----------------------------------------
    // Register file
    // ----------------------------------------
    assign rf_write = retire_fire && ws_bus_r.rf_we && ws_bus_r.rd != '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < RF_DEPTH; i++) begin
                rf[i] <= '0;
            end
        end else if (rf_write) begin
            rf[ws_bus_r.rd] <= ws_bus_r.final_result;
        end
    end

    // x0 hardwired
    assign rs1_data = (rs1_addr == '0) ? '0 : rf[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : rf[rs2_addr];

    always_comb begin
        ws_forward.valid = ws_valid && ws_bus_r.rf_we && ws_bus_r.rd != '0;
        ws_forward.rd    = ws_bus_r.rd;
        ws_forward.value = ws_bus_r.final_result;
    end

endmodule

`default_nettype wire

// ==== tests/tb_lsu_pipe.sv ====
/*
 * Testbench for the pipeline back end
 * Random instruction stream under retire back-pressure, checked against
 * a register and byte-memory model updated in program order
 */

`timescale 1ns/1ps
`default_nettype none

module tb_lsu_pipe
    import core_cfg_pkg::*;
    import stage_bus_pkg::*;
();

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 16;
    localparam int IDLE_CYCLES  = 5;
    localparam int NUM_INSTR    = 2000;
    localparam int DRAIN_LIMIT  = 200;
    localparam int WATCHDOG_NS  = (RESET_CYCLES + IDLE_CYCLES + 30 * NUM_INSTR) * CLK_PERIOD;
    localparam int MEM_BYTES    = 256 * 8;

    logic          clk = 1'b0;
    logic          reset;
    logic          in_valid;
    issue_bus_t    in_bus;
    logic          in_allowin;
    logic          retire_valid;
    ms_to_ws_bus_t retire_bus;
    logic          retire_ready;

    // Reference model state
    logic [XLEN-1:0]      model_rf [32];
    logic [7:0]           model_mem [MEM_BYTES];
    ms_to_ws_bus_t        expect_q [$];
    logic [63:0]          lcg_state;
    logic [RF_ADDR_W-1:0] last_rd;
    logic [RF_ADDR_W-1:0] prev_rd;

    int issued_count;
    int accepted_count;
    int retired_count;
    int edge_count;
    int first_accept_edge;
    int mismatch_count;
    int protocol_count;
    int end_count;

    lsu_pipe_top #(
        .DMEM_WORDS(256)
    ) dut_i (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .in_bus      (in_bus),
        .in_allowin  (in_allowin),
        .retire_valid(retire_valid),
        .retire_bus  (retire_bus),
        .retire_ready(retire_ready)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ----------------------------------------
    // Random source and model helpers
    // ----------------------------------------
    function logic [31:0] next_random();
        lcg_state = lcg_state * 64'd6364136223846793005 + 64'd1442695040888963407;
        return lcg_state[63:32];
    endfunction

    // Mostly x0..x5 so that dependences are common
    function logic [RF_ADDR_W-1:0] pick_reg();
        logic [31:0] r;
        r = next_random();
        if (r[1:0] != 2'b00) begin
            return RF_ADDR_W'(r[15:8] % 8'd6);
        end
        return r[20:16];
    endfunction

    // Little-endian read of 1 << size bytes, then extension
    function automatic logic [XLEN-1:0] read_model_mem(
        input logic [XLEN-1:0] addr,
        input mem_size_t       size,
        input logic            sign_ext
    );
        logic [XLEN-1:0] value;
        logic [10:0]     idx;
        int              n;
        value = '0;
        n = 1 << int'(size);
        for (int i = 0; i < n; i++) begin
            idx = addr[10:0] + 11'(i);
            value[i*8 +: 8] = model_mem[idx];
        end
        if (sign_ext && value[n*8-1]) begin
            value = value | ~((64'd1 << (n * 8)) - 64'd1);
        end
        return value;
    endfunction

    task automatic write_model_mem(
        input logic [XLEN-1:0] addr,
        input mem_size_t       size,
        input logic [XLEN-1:0] data
    );
        logic [10:0] idx;
        for (int i = 0; i < (1 << int'(size)); i++) begin
            idx = addr[10:0] + 11'(i);
            model_mem[idx] = data[i*8 +: 8];
        end
    endtask

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    task automatic make_instr();
        logic [31:0]     r;
        int              word;
        int              off;
        logic [XLEN-1:0] target;
        r = next_random();
        in_bus.pc       = PC_W'(issued_count * 4);
        in_bus.rs1      = pick_reg();
        in_bus.rs2      = pick_reg();
        in_bus.rd       = pick_reg();
        in_bus.size     = mem_size_t'(r[5:4]);
        in_bus.sign_ext = r[6];
        // Read the last or second-to-last destination
        if (r[8:7] != 2'b00) begin
            in_bus.rs1 = r[9] ? last_rd : prev_rd;
        end
        if (r[11:10] == 2'b11) begin
            in_bus.rs2 = last_rd;
        end
        if (r[15:12] < 4'd6) begin
            in_bus.kind = OP_ADDI;
        end else if (r[15:12] < 4'd11) begin
            in_bus.kind = OP_LOAD;
        end else begin
            in_bus.kind = OP_STORE;
        end
        if (in_bus.kind == OP_ADDI) begin
            if (r[17]) begin
                in_bus.imm = {{(XLEN-12){r[31]}}, r[31:20]};
            end else begin
                in_bus.imm = {next_random(), next_random()};
            end
        end else begin
            // Naturally aligned, often within the first eight words
            word = r[18] ? int'(r[21:19]) : int'(r[29:24]);
            off  = int'(r[2:0]) & ~((1 << int'(in_bus.size)) - 1);
            target = XLEN'(word * 8 + off);
            in_bus.imm = target - model_rf[in_bus.rs1];
        end
        prev_rd = last_rd;
        last_rd = in_bus.rd;
        issued_count++;
    endtask

    task automatic drive_inputs();
        logic [31:0] r;
        r = next_random();
        // A held instruction stays until it is taken
        if (accepted_count == issued_count) begin
            if (issued_count < NUM_INSTR && r[2:0] != 3'b000) begin
                make_instr();
                in_valid = 1'b1;
            end else begin
                in_valid = 1'b0;
            end
        end
        retire_ready = (retired_count == 0) || (r[9:8] != 2'b00);
    endtask

    // ----------------------------------------
    // Acceptance and retire checking
    // ----------------------------------------
    task report_mismatch(input string what, input logic [XLEN-1:0] got,
                         input logic [XLEN-1:0] want);
        $display("FAILED %0t: retire %s is %h, expected %h (pc %h)",
                 $time, what, got, want, retire_bus.pc);
        mismatch_count++;
    endtask

    task accept_instr();
        ms_to_ws_bus_t   exp;
        logic [XLEN-1:0] addr;
        addr = model_rf[in_bus.rs1] + in_bus.imm;
        exp.pc           = in_bus.pc;
        exp.rd           = in_bus.rd;
        exp.rf_we        = in_bus.kind != OP_STORE;
        exp.final_result = addr;
        if (in_bus.kind == OP_LOAD) begin
            exp.final_result = read_model_mem(addr, in_bus.size, in_bus.sign_ext);
        end
        if (in_bus.kind == OP_STORE) begin
            write_model_mem(addr, in_bus.size, model_rf[in_bus.rs2]);
        end
        if (exp.rf_we && exp.rd != '0) begin
            model_rf[exp.rd] = exp.final_result;
        end
        expect_q.push_back(exp);
        if (accepted_count == 0) begin
            first_accept_edge = edge_count;
        end
        accepted_count++;
    endtask

    task check_retire();
        ms_to_ws_bus_t exp;
        assert (expect_q.size() != 0) else begin
            $display("Unexpected retire at %0t with no instruction outstanding", $time);
            protocol_count++;
        end
        if (expect_q.size() != 0) begin
            exp = expect_q.pop_front();
            if (retired_count == 0) begin
                assert (edge_count == first_accept_edge + 3) else begin
                    $display("First retire came %0d edges after acceptance instead of 3",
                             edge_count - first_accept_edge);
                    protocol_count++;
                end
            end
            assert (retire_bus.pc == exp.pc)
                else report_mismatch("pc", XLEN'(retire_bus.pc), XLEN'(exp.pc));
            assert (retire_bus.rd == exp.rd)
                else report_mismatch("rd", XLEN'(retire_bus.rd), XLEN'(exp.rd));
            assert (retire_bus.rf_we == exp.rf_we)
                else report_mismatch("rf_we", XLEN'(retire_bus.rf_we), XLEN'(exp.rf_we));
            assert (retire_bus.final_result == exp.final_result)
                else report_mismatch("result", retire_bus.final_result, exp.final_result);
            retired_count++;
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                model_rf[i] = '0;
            end
            for (int i = 0; i < MEM_BYTES; i++) begin
                model_mem[i] = '0;
            end
            expect_q.delete();
            accepted_count = 0;
            retired_count  = 0;
            edge_count     = 0;
            mismatch_count = 0;
            protocol_count = 0;
        end else begin
            edge_count++;
            if (accepted_count == 0) begin
                assert (!retire_valid && in_allowin) else begin
                    $display("Pipeline not idle at %0t before the first instruction", $time);
                    protocol_count++;
                end
            end
            if (retire_valid && retire_ready) begin
                check_retire();
            end
            if (in_valid && in_allowin) begin
                accept_instr();
            end
        end
    end

    // ----------------------------------------
    // Run control
    // ----------------------------------------
    task print_summary();
        $display("Summary: %0d value mismatches, %0d other errors, %0d of %0d retired",
                 mismatch_count, protocol_count + end_count, retired_count, NUM_INSTR);
    endtask

    initial begin
        int drain;
        reset        = 1'b1;
        in_valid     = 1'b0;
        in_bus       = '0;
        retire_ready = 1'b1;
        lcg_state    = 64'd11;
        last_rd      = '0;
        prev_rd      = '0;
        issued_count = 0;
        end_count    = 0;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        repeat (IDLE_CYCLES) @(negedge clk);

        while (accepted_count < NUM_INSTR) begin
            @(negedge clk);
            drive_inputs();
        end

        drain = 0;
        while (expect_q.size() != 0 && drain < DRAIN_LIMIT) begin
            @(negedge clk);
            drive_inputs();
            drain++;
        end
        // Idle tail to catch any extra retire
        retire_ready = 1'b1;
        repeat (8) @(negedge clk);

        assert (retired_count == NUM_INSTR) else begin
            $display("Missing retire: %0d of %0d instructions retired",
                     retired_count, NUM_INSTR);
            end_count++;
        end
        assert (expect_q.size() == 0) else begin
            $display("Expected queue not empty: %0d records left", expect_q.size());
            end_count++;
        end

        print_summary();
        if (mismatch_count == 0 && protocol_count == 0 && end_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout after %0d ns with %0d of %0d instructions retired",
                 WATCHDOG_NS, retired_count, NUM_INSTR);
        print_summary();
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire
